//--- source/llc_cfg_pkg.sv
`default_nettype none

package llc_cfg_pkg;

    // Cache geometry
    localparam int LLC_SET_BITS  = 4;
    localparam int LLC_TAG_BITS  = 8;
    localparam int LLC_LINE_BITS = 128;
    localparam int LLC_ID_BITS   = 4;
    localparam int LLC_ADDR_BITS = LLC_TAG_BITS + LLC_SET_BITS;
    localparam int LLC_SETS      = 2 ** LLC_SET_BITS;

    // Line address holds the tag above the set index
    typedef logic [LLC_ADDR_BITS-1:0] line_addr_t;
    typedef logic [LLC_SET_BITS-1:0]  llc_set_t;
    typedef logic [LLC_TAG_BITS-1:0]  llc_tag_t;
    typedef logic [LLC_LINE_BITS-1:0] line_t;
    typedef logic [LLC_ID_BITS-1:0]   req_id_t;

    function automatic llc_set_t addr_set(line_addr_t addr);
        return addr[LLC_SET_BITS-1:0];
    endfunction

    function automatic llc_tag_t addr_tag(line_addr_t addr);
        return addr[LLC_ADDR_BITS-1:LLC_SET_BITS];
    endfunction

endpackage

`default_nettype wire

//--- source/llc_msg_pkg.sv
`default_nettype none

package llc_msg_pkg;

    // Request kinds, shared by the requester and the memory side
    typedef logic req_kind_t;
    localparam req_kind_t REQ_READ  = 1'b0;
    localparam req_kind_t REQ_WRITE = 1'b1;

    // Sequencer phases, neighbouring phases differ in one bit
    typedef enum logic [2:0] {
        DECODE   = 3'b000,
        READ_SET = 3'b001,
        READ_MEM = 3'b011,
        LOOKUP   = 3'b010,
        PROCESS  = 3'b110,
        UPDATE   = 3'b100
    } llc_phase_e;

    typedef enum logic [2:0] {
        IDLE,
        WB_REQ,
        FILL_REQ,
        FILL_WAIT,
        RESPOND,
        DONE
    } proc_state_e;

endpackage

`default_nettype wire

//--- source/llc_req_if.sv
`timescale 1ns/100ps
`default_nettype none

interface llc_req_if import llc_cfg_pkg::*, llc_msg_pkg::*; ();

    // Captured request, held until the next acceptance
    req_kind_t  kind;
    line_addr_t addr;
    line_t      line;
    req_id_t    id;

    modport stage (output kind, output addr, output line, output id);

    modport user (input kind, input addr, input line, input id);

endinterface

`default_nettype wire

//--- source/llc_array_if.sv
`timescale 1ns/100ps
`default_nettype none

interface llc_array_if import llc_cfg_pkg::*; #(
    parameter int WAYS = 4
) ();

    localparam int WAY_BITS = $clog2(WAYS);

    // Read side, data returns one cycle after rd_set
    llc_set_t            rd_set;
    llc_tag_t            rd_tag [WAYS];
    logic [WAYS-1:0]     rd_valid;
    logic [WAYS-1:0]     rd_dirty;
    line_t               rd_line [WAYS];
    logic [WAY_BITS-1:0] rd_evict;

    // Write side rewrites every way of wr_set
    logic                wr_en;
    llc_set_t            wr_set;
    llc_tag_t            wr_tag [WAYS];
    logic [WAYS-1:0]     wr_valid;
    logic [WAYS-1:0]     wr_dirty;
    line_t               wr_line [WAYS];
    logic [WAY_BITS-1:0] wr_evict;

    modport store (
        input  rd_set, wr_en, wr_set, wr_tag, wr_valid, wr_dirty, wr_line, wr_evict,
        output rd_tag, rd_valid, rd_dirty, rd_line, rd_evict
    );

    modport buffer (
        output rd_set, wr_en, wr_set, wr_tag, wr_valid, wr_dirty, wr_line, wr_evict,
        input  rd_tag, rd_valid, rd_dirty, rd_line, rd_evict
    );

endinterface

`default_nettype wire

//--- source/llc_buf_if.sv
`timescale 1ns/100ps
`default_nettype none

interface llc_buf_if import llc_cfg_pkg::*; #(
    parameter int WAYS = 4
) ();

    localparam int WAY_BITS = $clog2(WAYS);

    // Lookup result of the buffered set
    logic                hit;
    logic [WAY_BITS-1:0] way;
    logic                victim_dirty;
    line_addr_t          victim_addr;
    line_t               cur_line;

    // Edits to the chosen way
    logic                line_we;
    line_t               line_wd;
    logic                fill_tag;
    logic                set_dirty;
    logic                alloc;

    modport buffer (
        output hit, way, victim_dirty, victim_addr, cur_line,
        input  line_we, line_wd, fill_tag, set_dirty, alloc
    );

    modport proc (
        input  hit, way, victim_dirty, victim_addr, cur_line,
        output line_we, line_wd, fill_tag, set_dirty, alloc
    );

endinterface

`default_nettype wire

//--- source/llc_input_stage.sv
`timescale 1ns/100ps
`default_nettype none

module llc_input_stage import llc_cfg_pkg::*, llc_msg_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             decode_en_i,
    input  wire             req_valid_i,
    output logic            req_ready_o,
    input  wire req_kind_t  req_kind_i,
    input  wire line_addr_t req_addr_i,
    input  wire line_t      req_line_i,
    input  wire req_id_t    req_id_i,
    llc_req_if.stage        req
);

    // Ready rises one cycle into decode and drops on the accepting edge
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_ready_o <= 1'b0;
        end else begin
            req_ready_o <= decode_en_i && !(req_valid_i && req_ready_o);
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req.kind <= req_kind_i;
            req.addr <= req_addr_i;
            req.line <= req_line_i;
            req.id   <= req_id_i;
        end
    end

endmodule

`default_nettype wire

//--- source/llc_localmem.sv
`timescale 1ns/100ps
`default_nettype none

module llc_localmem import llc_cfg_pkg::*; #(
    parameter int WAYS = 4
) (
    input  wire        clk,
    input  wire        rst,
    llc_array_if.store arr
);

    localparam int WAY_BITS = $clog2(WAYS);

    llc_tag_t            tag_mem   [LLC_SETS][WAYS];
    line_t               line_mem  [LLC_SETS][WAYS];
    logic [WAYS-1:0]     valid_mem [LLC_SETS];
    logic [WAYS-1:0]     dirty_mem [LLC_SETS];
    logic [WAY_BITS-1:0] evict_mem [LLC_SETS];

    // Tag and line arrays
    always_ff @(posedge clk) begin
        if (arr.wr_en) begin
            tag_mem[arr.wr_set]  <= arr.wr_tag;
            line_mem[arr.wr_set] <= arr.wr_line;
        end
        arr.rd_tag  <= tag_mem[arr.rd_set];
        arr.rd_line <= line_mem[arr.rd_set];
    end

    // State bits and evict pointers, all sets empty after reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < LLC_SETS; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
                evict_mem[s] <= '0;
            end
            arr.rd_valid <= '0;
            arr.rd_dirty <= '0;
            arr.rd_evict <= '0;
        end else begin
            if (arr.wr_en) begin
                valid_mem[arr.wr_set] <= arr.wr_valid;
                dirty_mem[arr.wr_set] <= arr.wr_dirty;
                evict_mem[arr.wr_set] <= arr.wr_evict;
            end
            arr.rd_valid <= valid_mem[arr.rd_set];
            arr.rd_dirty <= dirty_mem[arr.rd_set];
            arr.rd_evict <= evict_mem[arr.rd_set];
        end
    end

endmodule

`default_nettype wire

//--- source/llc_way_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module llc_way_buffer import llc_cfg_pkg::*; #(
    parameter int WAYS = 4
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         rd_set_en_i,
    input  wire         rd_mem_en_i,
    input  wire         lookup_en_i,
    input  wire         update_en_i,
    llc_req_if.user     req,
    llc_array_if.buffer arr,
    llc_buf_if.buffer   buf_io
);

    localparam int WAY_BITS = $clog2(WAYS);

    llc_set_t            set_q;
    llc_tag_t            tags_q  [WAYS];
    line_t               lines_q [WAYS];
    logic [WAYS-1:0]     valid_q;
    logic [WAYS-1:0]     dirty_q;
    logic [WAY_BITS-1:0] evict_q;
    logic                hit_c;
    logic [WAY_BITS-1:0] way_c;

    assign arr.rd_set = addr_set(req.addr);

    // Whole set goes back to the store in the update phase
    assign arr.wr_en    = update_en_i;
    assign arr.wr_set   = set_q;
    assign arr.wr_tag   = tags_q;
    assign arr.wr_valid = valid_q;
    assign arr.wr_dirty = dirty_q;
    assign arr.wr_line  = lines_q;
    assign arr.wr_evict = evict_q;

    assign buf_io.cur_line = lines_q[buf_io.way];

    // Hit way first, then lowest invalid way, then the evict pointer
    always_comb begin
        hit_c = 1'b0;
        way_c = evict_q;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid_q[w]) begin
                way_c = WAY_BITS'(w);
            end
        end
        for (int w = 0; w < WAYS; w++) begin
            if (valid_q[w] && tags_q[w] == addr_tag(req.addr)) begin
                hit_c = 1'b1;
                way_c = WAY_BITS'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q             <= '0;
            dirty_q             <= '0;
            evict_q             <= '0;
            buf_io.hit          <= 1'b0;
            buf_io.way          <= '0;
            buf_io.victim_dirty <= 1'b0;
        end else if (rd_mem_en_i) begin
            valid_q <= arr.rd_valid;
            dirty_q <= arr.rd_dirty;
            evict_q <= arr.rd_evict;
        end else begin
            if (lookup_en_i) begin
                buf_io.hit          <= hit_c;
                buf_io.way          <= way_c;
                buf_io.victim_dirty <= !hit_c && valid_q[way_c] && dirty_q[way_c];
            end
            if (buf_io.line_we) begin
                dirty_q[buf_io.way] <= buf_io.set_dirty;
            end
            if (buf_io.fill_tag) begin
                valid_q[buf_io.way] <= 1'b1;
            end
            // Pointer wraps since WAYS is a power of two
            if (buf_io.alloc) begin
                evict_q <= buf_io.way + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_set_en_i) begin
            set_q <= addr_set(req.addr);
        end
        if (rd_mem_en_i) begin
            tags_q  <= arr.rd_tag;
            lines_q <= arr.rd_line;
        end else begin
            if (buf_io.line_we) begin
                lines_q[buf_io.way] <= buf_io.line_wd;
            end
            if (buf_io.fill_tag) begin
                tags_q[buf_io.way] <= addr_tag(req.addr);
            end
        end
        if (lookup_en_i) begin
            buf_io.victim_addr <= {tags_q[way_c], set_q};
        end
    end

endmodule

`default_nettype wire

//--- source/llc_process.sv
`timescale 1ns/100ps
`default_nettype none

module llc_process import llc_cfg_pkg::*, llc_msg_pkg::*; #(
    parameter int WAYS = 4
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             process_en_i,
    output logic            done_o,
    llc_req_if.user         req,
    llc_buf_if.proc         buf_io,
    output logic            mem_req_valid_o,
    input  wire             mem_req_ready_i,
    output req_kind_t       mem_req_kind_o,
    output line_addr_t      mem_req_addr_o,
    output line_t           mem_req_line_o,
    input  wire             mem_rsp_valid_i,
    output logic            mem_rsp_ready_o,
    input  wire line_t      mem_rsp_line_i,
    output logic            rsp_valid_o,
    input  wire             rsp_ready_i,
    output line_t           rsp_line_o,
    output req_id_t         rsp_id_o
);

    // Way count must be a power of two, at least 2
    if (WAYS < 2 || (WAYS & (WAYS - 1)) != 0) begin : g_ways_check
        $error("llc_process: WAYS must be a power of two and at least 2");
    end

    proc_state_e state_q;
    logic        is_write;

    assign is_write = (req.kind == REQ_WRITE);

    // Write-back of the victim, or fill read of the request address
    assign mem_req_valid_o = (state_q == WB_REQ) || (state_q == FILL_REQ);
    assign mem_req_kind_o  = (state_q == WB_REQ) ? REQ_WRITE : REQ_READ;
    assign mem_req_addr_o  = (state_q == WB_REQ) ? buf_io.victim_addr : req.addr;
    assign mem_req_line_o  = (state_q == WB_REQ) ? buf_io.cur_line : '0;
    assign mem_rsp_ready_o = (state_q == FILL_WAIT);

    assign rsp_valid_o = (state_q == RESPOND);
    assign rsp_id_o    = req.id;
    assign done_o      = rsp_valid_o && rsp_ready_i;

    // Way edits land on the response transfer
    assign buf_io.line_we   = done_o && (is_write || !buf_io.hit);
    assign buf_io.line_wd   = is_write ? req.line : rsp_line_o;
    assign buf_io.fill_tag  = done_o && !buf_io.hit;
    assign buf_io.set_dirty = is_write;
    assign buf_io.alloc     = done_o && !buf_io.hit;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (process_en_i) begin
                        if (buf_io.hit) begin
                            state_q <= RESPOND;
                        end else if (buf_io.victim_dirty) begin
                            state_q <= WB_REQ;
                        end else begin
                            state_q <= is_write ? RESPOND : FILL_REQ;
                        end
                    end
                end
                WB_REQ: begin
                    if (mem_req_ready_i) begin
                        state_q <= is_write ? RESPOND : FILL_REQ;
                    end
                end
                FILL_REQ: begin
                    if (mem_req_ready_i) begin
                        state_q <= FILL_WAIT;
                    end
                end
                FILL_WAIT: begin
                    if (mem_rsp_valid_i) begin
                        state_q <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (rsp_ready_i) begin
                        state_q <= DONE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Hit line on a read hit, fill line on a read miss, zero for a write
    always_ff @(posedge clk) begin
        if (state_q == IDLE && process_en_i) begin
            rsp_line_o <= (buf_io.hit && !is_write) ? buf_io.cur_line : '0;
        end else if (mem_rsp_ready_o && mem_rsp_valid_i) begin
            rsp_line_o <= mem_rsp_line_i;
        end
    end

endmodule

`default_nettype wire

//--- source/llc_top.sv
`timescale 1ns/100ps
`default_nettype none

module llc_top import llc_cfg_pkg::*, llc_msg_pkg::*; #(
    parameter int WAYS = 4
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             req_valid_i,
    output logic            req_ready_o,
    input  wire req_kind_t  req_kind_i,
    input  wire line_addr_t req_addr_i,
    input  wire line_t      req_line_i,
    input  wire req_id_t    req_id_i,
    output logic            rsp_valid_o,
    input  wire             rsp_ready_i,
    output line_t           rsp_line_o,
    output req_id_t         rsp_id_o,
    output logic            mem_req_valid_o,
    input  wire             mem_req_ready_i,
    output req_kind_t       mem_req_kind_o,
    output line_addr_t      mem_req_addr_o,
    output line_t           mem_req_line_o,
    input  wire             mem_rsp_valid_i,
    output logic            mem_rsp_ready_o,
    input  wire line_t      mem_rsp_line_i
);

    llc_phase_e phase;
    llc_phase_e phase_next;
    logic       decode_en;
    logic       rd_set_en;
    logic       rd_mem_en;
    logic       lookup_en;
    logic       process_en;
    logic       update_en;
    logic       proc_done;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase <= DECODE;
        end else begin
            phase <= phase_next;
        end
    end

    // Fixed walk through the phases, waiting on acceptance and on done
    always_comb begin
        phase_next = phase;
        case (phase)
            DECODE: begin
                if (req_valid_i && req_ready_o) begin
                    phase_next = READ_SET;
                end
            end
            READ_SET: phase_next = READ_MEM;
            READ_MEM: phase_next = LOOKUP;
            LOOKUP:   phase_next = PROCESS;
            PROCESS: begin
                if (proc_done) begin
                    phase_next = UPDATE;
                end
            end
            default:  phase_next = DECODE;
        endcase
    end

    assign decode_en  = (phase == DECODE);
    assign rd_set_en  = (phase == READ_SET);
    assign rd_mem_en  = (phase == READ_MEM);
    assign lookup_en  = (phase == LOOKUP);
    assign process_en = (phase == PROCESS);
    assign update_en  = (phase == UPDATE);

    llc_req_if                     req_bus ();
    llc_array_if #(.WAYS(WAYS))    arr_bus ();
    llc_buf_if   #(.WAYS(WAYS))    buf_bus ();

    llc_input_stage u_input_stage (
        .clk         (clk),
        .rst         (rst),
        .decode_en_i (decode_en),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_kind_i  (req_kind_i),
        .req_addr_i  (req_addr_i),
        .req_line_i  (req_line_i),
        .req_id_i    (req_id_i),
        .req         (req_bus.stage)
    );

    llc_localmem #(.WAYS(WAYS)) u_localmem (
        .clk (clk),
        .rst (rst),
        .arr (arr_bus.store)
    );

    llc_way_buffer #(.WAYS(WAYS)) u_way_buffer (
        .clk         (clk),
        .rst         (rst),
        .rd_set_en_i (rd_set_en),
        .rd_mem_en_i (rd_mem_en),
        .lookup_en_i (lookup_en),
        .update_en_i (update_en),
        .req         (req_bus.user),
        .arr         (arr_bus.buffer),
        .buf_io      (buf_bus.buffer)
    );

    llc_process #(.WAYS(WAYS)) u_process (
        .clk             (clk),
        .rst             (rst),
        .process_en_i    (process_en),
        .done_o          (proc_done),
        .req             (req_bus.user),
        .buf_io          (buf_bus.proc),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_kind_o  (mem_req_kind_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_line_o  (mem_req_line_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .mem_rsp_line_i  (mem_rsp_line_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_line_o      (rsp_line_o),
        .rsp_id_o        (rsp_id_o)
    );

endmodule

`default_nettype wire

//--- testbench/llc_properties.sv
`timescale 1ns/100ps
`default_nettype none

module llc_properties import llc_cfg_pkg::*, llc_msg_pkg::*; (
    input wire             clk,
    input wire             rst,
    input wire             req_valid_i,
    input wire             req_ready_i,
    input wire llc_phase_e phase_i,
    input wire             rsp_valid_i,
    input wire             rsp_ready_i,
    input wire line_t      rsp_line_i,
    input wire req_id_t    rsp_id_i,
    input wire             mem_req_valid_i,
    input wire             mem_req_ready_i,
    input wire req_kind_t  mem_req_kind_i,
    input wire line_addr_t mem_req_addr_i,
    input wire line_t      mem_req_line_i,
    input wire             mem_rsp_valid_i,
    input wire             mem_rsp_ready_i
);

    // Requests are only taken in the decode phase
    ready_in_decode: assert property (@(posedge clk) disable iff (!rst)
        req_ready_i |-> phase_i == DECODE)
        else $error("req_ready_o high outside DECODE");

    req_held: assert property (@(posedge clk) disable iff (!rst)
        req_valid_i && !req_ready_i |=> req_valid_i)
        else $error("req_valid_i dropped before its transfer");

    rsp_held: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_i && !rsp_ready_i |=>
            rsp_valid_i && $stable(rsp_line_i) && $stable(rsp_id_i))
        else $error("response changed while held");

    mem_req_held: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_i && !mem_req_ready_i |=>
            mem_req_valid_i && $stable(mem_req_kind_i) && $stable(mem_req_addr_i)
            && $stable(mem_req_line_i))
        else $error("memory request changed while held");

    mem_rsp_held: assert property (@(posedge clk) disable iff (!rst)
        mem_rsp_valid_i && !mem_rsp_ready_i |=> mem_rsp_valid_i)
        else $error("mem_rsp_valid_i dropped before its transfer");

    // Outputs start idle in the first cycle after reset is released
    idle_after_reset: assert property (@(posedge clk)
        $rose(rst) |-> !req_ready_i && !rsp_valid_i && !mem_req_valid_i && !mem_rsp_ready_i)
        else $error("outputs not idle after reset");

endmodule

bind llc_top llc_properties i_props (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (req_valid_i),
    .req_ready_i     (req_ready_o),
    .phase_i         (phase),
    .rsp_valid_i     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_line_i      (rsp_line_o),
    .rsp_id_i        (rsp_id_o),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_kind_i  (mem_req_kind_o),
    .mem_req_addr_i  (mem_req_addr_o),
    .mem_req_line_i  (mem_req_line_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_ready_i (mem_rsp_ready_o)
);

`default_nettype wire

//--- testbench/llc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module llc_tb import llc_cfg_pkg::*, llc_msg_pkg::*;;

    localparam int WAYS    = 4;
    localparam int TIMEOUT = 200;

    logic       clk;
    logic       rst;
    logic       req_valid;
    logic       req_ready;
    req_kind_t  req_kind;
    line_addr_t req_addr;
    line_t      req_line;
    req_id_t    req_id;
    logic       rsp_valid;
    logic       rsp_ready;
    line_t      rsp_line;
    req_id_t    rsp_id;
    logic       mem_req_valid;
    logic       mem_req_ready;
    req_kind_t  mem_req_kind;
    line_addr_t mem_req_addr;
    line_t      mem_req_line;
    logic       mem_rsp_valid;
    logic       mem_rsp_ready;
    line_t      mem_rsp_line;

    int          errors;
    int          checks;
    bit          timed_out;
    bit          bp_mode;
    logic [15:0] lfsr_state;

    // Memory traffic seen by the model in order of transfer
    req_kind_t   ev_kind [$];
    line_addr_t  ev_addr [$];
    line_t       ev_line [$];
    bit          fill_pending;
    line_addr_t  fill_addr;

    // Reference cache contents
    llc_tag_t    m_tag   [LLC_SETS][WAYS];
    bit          m_valid [LLC_SETS][WAYS];
    bit          m_dirty [LLC_SETS][WAYS];
    line_t       m_line  [LLC_SETS][WAYS];
    int          m_ptr   [LLC_SETS];

    llc_top #(.WAYS(WAYS)) i_dut (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid),
        .req_ready_o     (req_ready),
        .req_kind_i      (req_kind),
        .req_addr_i      (req_addr),
        .req_line_i      (req_line),
        .req_id_i        (req_id),
        .rsp_valid_o     (rsp_valid),
        .rsp_ready_i     (rsp_ready),
        .rsp_line_o      (rsp_line),
        .rsp_id_o        (rsp_id),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_req_kind_o  (mem_req_kind),
        .mem_req_addr_o  (mem_req_addr),
        .mem_req_line_o  (mem_req_line),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_ready_o (mem_rsp_ready),
        .mem_rsp_line_i  (mem_rsp_line)
    );

    always #50 clk = ~clk;

    // Memory content for a line address with every word tied to the full address
    function automatic line_t fill_line(line_addr_t a);
        line_t l;
        for (int i = 0; i < 4; i++) begin
            l[i*32 +: 32] = {a, 4'(i), a[7:0] ^ 8'h5A, 8'hC3};
        end
        return l;
    endfunction

    // Galois LFSR stepped once for every random bit
    function automatic bit next_random_bit();
        bit b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        return b;
    endfunction

    task automatic expect_true(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Fail at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic report_timeout(input string msg);
        errors++;
        timed_out = 1'b1;
        $display("Timeout at %0t ns: %s", $time, msg);
    endtask

    // Ready inputs go random only while back-pressure is on
    always @(posedge clk) begin : drive_ready
        #10;
        if (bp_mode) begin
            rsp_ready = next_random_bit();
            mem_req_ready = next_random_bit();
        end else begin
            rsp_ready = 1'b1;
            mem_req_ready = 1'b1;
        end
    end

    // Memory model answers a fill one cycle after its request
    always @(posedge clk) begin
        if (mem_rsp_ready) begin
            expect_true(fill_pending, "mem_rsp_ready_o high without a pending fill");
        end
        if (mem_req_valid && mem_req_ready) begin
            ev_kind.push_back(mem_req_kind);
            ev_addr.push_back(mem_req_addr);
            ev_line.push_back(mem_req_line);
            if (mem_req_kind == REQ_READ) begin
                fill_pending = 1'b1;
                fill_addr = mem_req_addr;
            end
        end
        if (mem_rsp_valid && mem_rsp_ready) begin
            fill_pending = 1'b0;
        end
        #10;
        mem_rsp_valid = fill_pending;
        mem_rsp_line = fill_pending ? fill_line(fill_addr) : '0;
    end

    // Sends one request, predicts its outcome and checks response and traffic
    task automatic run_request(input req_kind_t kind, input line_addr_t addr,
                               input line_t wdata, input req_id_t id,
                               output int rise_edge);
        int         s;
        llc_tag_t   t;
        int         way;
        bit         hit;
        bit         accepted;
        bit         got;
        bit         held;
        line_t      held_line;
        req_id_t    held_id;
        line_t      exp_line;
        req_kind_t  exp_kind [$];
        line_addr_t exp_addr [$];
        line_t      exp_mline [$];
        int         cnt;
        int         first_seen;
        int         n;
        rise_edge = -1;
        if (timed_out) begin
            return;
        end
        s = int'(addr[LLC_SET_BITS-1:0]);
        t = addr[LLC_TAG_BITS+LLC_SET_BITS-1:LLC_SET_BITS];
        hit = 1'b0;
        way = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!m_valid[s][w]) begin
                    way = w;
                end
            end
            if (way < 0) begin
                way = m_ptr[s];
            end
            if (m_valid[s][way] && m_dirty[s][way]) begin
                exp_kind.push_back(REQ_WRITE);
                exp_addr.push_back({m_tag[s][way], 4'(s)});
                exp_mline.push_back(m_line[s][way]);
            end
            if (kind == REQ_READ) begin
                exp_kind.push_back(REQ_READ);
                exp_addr.push_back(addr);
                exp_mline.push_back('0);
            end
        end
        if (kind == REQ_WRITE) begin
            exp_line = '0;
            m_line[s][way] = wdata;
            m_dirty[s][way] = 1'b1;
        end else if (hit) begin
            exp_line = m_line[s][way];
        end else begin
            exp_line = fill_line(addr);
            m_line[s][way] = exp_line;
            m_dirty[s][way] = 1'b0;
        end
        if (!hit) begin
            m_tag[s][way] = t;
            m_valid[s][way] = 1'b1;
            m_ptr[s] = (way + 1) % WAYS;
        end
        ev_kind.delete();
        ev_addr.delete();
        ev_line.delete();

        @(posedge clk);
        #10;
        req_valid = 1'b1;
        req_kind = kind;
        req_addr = addr;
        req_line = wdata;
        req_id = id;
        accepted = 1'b0;
        cnt = 0;
        while (!accepted && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
            accepted = req_ready;
        end
        if (!accepted) begin
            report_timeout("request was never accepted");
            return;
        end
        #10;
        req_valid = 1'b0;

        got = 1'b0;
        held = 1'b0;
        first_seen = -1;
        n = 0;
        while (!got && n < TIMEOUT) begin
            @(posedge clk);
            n++;
            if (rsp_valid && first_seen < 0) begin
                first_seen = n;
            end
            if (held && rsp_valid) begin
                expect_true(rsp_line == held_line && rsp_id == held_id,
                            "held response changed");
            end
            held = rsp_valid && !rsp_ready;
            held_line = rsp_line;
            held_id = rsp_id;
            got = rsp_valid && rsp_ready;
        end
        if (!got) begin
            report_timeout("no response arrived");
            return;
        end
        // Sampled values are the ones before the edge
        rise_edge = first_seen - 1;
        expect_true(rsp_id == id, $sformatf("response id %0h, expected %0h", rsp_id, id));
        expect_true(rsp_line == exp_line,
                    $sformatf("response line %h, expected %h", rsp_line, exp_line));
        expect_true(ev_kind.size() == exp_kind.size(),
                    $sformatf("%0d memory requests, expected %0d",
                              ev_kind.size(), exp_kind.size()));
        for (int i = 0; i < exp_kind.size() && i < ev_kind.size(); i++) begin
            expect_true(ev_kind[i] == exp_kind[i] && ev_addr[i] == exp_addr[i],
                        $sformatf("memory request %0d kind %0d addr %h, expected %0d %h",
                                  i, ev_kind[i], ev_addr[i], exp_kind[i], exp_addr[i]));
            if (exp_kind[i] == REQ_WRITE) begin
                expect_true(ev_line[i] == exp_mline[i],
                            $sformatf("write-back line %h, expected %h",
                                      ev_line[i], exp_mline[i]));
            end
        end
    endtask

    task automatic test_read_miss_empty();
        int e;
        run_request(REQ_READ, 12'h123, '0, 4'h5, e);
    endtask

    task automatic test_read_hit();
        int e;
        run_request(REQ_READ, 12'h123, '0, 4'h6, e);
        if (!timed_out) begin
            expect_true(e == 4, $sformatf("hit response rose on edge %0d, expected 4", e));
        end
    endtask

    task automatic test_write_then_read();
        int e;
        run_request(REQ_WRITE, 12'h2A7, {4{32'hDEAD_0001}}, 4'h9, e);
        run_request(REQ_READ, 12'h2A7, '0, 4'h3, e);
    endtask

    // Fill one set with dirty lines so that a new tag forces a write-back
    task automatic test_eviction();
        int e;
        for (int i = 0; i < WAYS; i++) begin
            run_request(REQ_WRITE, {8'(8'h10 + i), 4'hC}, {8{8'(i), 8'h3C}}, 4'(i), e);
        end
        run_request(REQ_READ, {8'h44, 4'hC}, '0, 4'hE, e);
    endtask

    task automatic test_back_pressure();
        int         e;
        llc_tag_t   tags [10];
        req_kind_t  kinds [10];
        tags  = '{8'h21, 8'h22, 8'h21, 8'h23, 8'h24, 8'h25, 8'h26, 8'h22, 8'h21, 8'h27};
        kinds = '{REQ_WRITE, REQ_WRITE, REQ_READ, REQ_READ, REQ_WRITE,
                  REQ_READ, REQ_WRITE, REQ_READ, REQ_READ, REQ_READ};
        bp_mode = 1'b1;
        for (int i = 0; i < 10; i++) begin
            run_request(kinds[i], {tags[i], 4'h5}, {8{8'(i), 8'hA5}}, 4'(i), e);
        end
        bp_mode = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        req_valid = 1'b0;
        req_kind = REQ_READ;
        req_addr = '0;
        req_line = '0;
        req_id = '0;
        rsp_ready = 1'b1;
        mem_req_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp_line = '0;
        fill_pending = 1'b0;
        fill_addr = '0;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        bp_mode = 1'b0;
        lfsr_state = 16'd17;
        for (int s = 0; s < LLC_SETS; s++) begin
            m_ptr[s] = 0;
            for (int w = 0; w < WAYS; w++) begin
                m_tag[s][w] = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_line[s][w] = '0;
            end
        end
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b1;

        test_read_miss_empty();
        test_read_hit();
        test_write_then_read();
        test_eviction();
        test_back_pressure();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
source/llc_cfg_pkg.sv
source/llc_msg_pkg.sv
source/llc_req_if.sv
source/llc_array_if.sv
source/llc_buf_if.sv
source/llc_input_stage.sv
source/llc_localmem.sv
source/llc_way_buffer.sv
source/llc_process.sv
source/llc_top.sv
testbench/llc_properties.sv
testbench/llc_tb.sv

//--- Makefile
# Verilator build and run of the LLC testbench

VERILATOR ?= verilator
TOP       ?= llc_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test OK" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
